// File: executeUnit.sv
`timescale 1ns/10ps
`default_nettype none

module executeUnit (
    input  pipePkg::ctrlT           ctrl,
    input  logic [isaPkg::IMM_W-1:0] imm,
    input  isaPkg::wordT            a,
    input  isaPkg::wordT            b,
    output isaPkg::wordT            result
);
    import isaPkg::*;
    import pipePkg::*;

    wordT immExt;
    wordT opB;

    assign immExt = ctrl.zeroExt ? {{(32 - IMM_W){1'b0}}, imm}
                                 : {{(32 - IMM_W){imm[IMM_W-1]}}, imm};
    assign opB    = ctrl.immB ? immExt : b;

    always_comb begin
        unique case (ctrl.aluOp)
            ALU_ADD: result = a + opB;
            ALU_SUB: result = a - opB;
            ALU_OR:  result = a | opB;
            // Upper half from the immediate, low half cleared
            ALU_LUI: result = {opB[15:0], 16'h0000};
            default: result = a + opB;
        endcase
    end

endmodule

`default_nettype wire

// File: fetchUnit.sv
`timescale 1ns/10ps
`default_nettype none

module fetchUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 stall,
    input  isaPkg::wordT         pcD,
    input  isaPkg::wordT         instrD,
    input  isaPkg::wordT         rsVal,
    input  isaPkg::wordT         rtVal,
    input  pipePkg::ctrlT        ctrlD,
    input  isaPkg::wordT         instRdata,
    output isaPkg::wordT         instAddr,
    output pipePkg::decodeStageT fetched
);
    import isaPkg::*;
    import pipePkg::*;

    wordT pc;
    wordT nextPc;
    wordT seqD;
    wordT branchOff;
    logic taken;

    // Targets are relative to the delay slot
    assign seqD      = pcD + 32'd4;
    assign branchOff = {{(30 - IMM_W){instrD[IMM_W-1]}}, instrD[IMM_W-1:0], 2'b00};
    assign taken     = ctrlD.branch && (rsVal == rtVal);

    always_comb begin
        if (taken) begin
            nextPc = seqD + branchOff;
        end else if (ctrlD.jump) begin
            nextPc = {seqD[31:28], instrD[INDEX_W-1:0], 2'b00};
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

    assign instAddr = pc;
    assign fetched  = '{instr: instRdata, pc: pc};

endmodule

`default_nettype wire

// File: hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  pipePkg::ctrlT   ctrlD,
    input  isaPkg::regIdxT  rsD,
    input  isaPkg::regIdxT  rtD,
    input  isaPkg::regIdxT  rsE,
    input  isaPkg::regIdxT  rtE,
    input  pipePkg::ctrlT   ctrlE,
    input  pipePkg::ctrlT   ctrlM,
    input  isaPkg::regIdxT  wbReg,
    output logic            stall,
    output pipePkg::fwdSrcT fwdRsD,
    output pipePkg::fwdSrcT fwdRtD,
    output pipePkg::fwdSrcT fwdRsE,
    output pipePkg::fwdSrcT fwdRtE
);
    import isaPkg::*;
    import pipePkg::*;

    timeT newE;
    timeT newM;
    logic stallRs;
    logic stallRt;

    // Remaining cycles until each stage's result exists
    assign newE = ctrlE.tnew;
    assign newM = (ctrlM.tnew == '0) ? '0 : timeT'(ctrlM.tnew - timeT'(1));

    assign stallRs = ctrlD.readsRs && rsD != '0 &&
                     ((rsD == ctrlE.wReg && ctrlD.tuseRs < newE) ||
                      (rsD == ctrlM.wReg && ctrlD.tuseRs < newM));
    assign stallRt = ctrlD.readsRt && rtD != '0 &&
                     ((rtD == ctrlE.wReg && ctrlD.tuseRt < newE) ||
                      (rtD == ctrlM.wReg && ctrlD.tuseRt < newM));
    assign stall   = stallRs || stallRt;

    // Youngest matching producer wins; if it is not ready, no forward yet
    function automatic fwdSrcT pickSrc(input regIdxT r, input logic fromE);
        if (r == '0) begin
            return FWD_RF;
        end
        if (fromE && r == ctrlE.wReg) begin
            return (newE == '0) ? FWD_E : FWD_RF;
        end
        if (r == ctrlM.wReg) begin
            return (newM == '0) ? FWD_M : FWD_RF;
        end
        if (r == wbReg) begin
            return FWD_W;
        end
        return FWD_RF;
    endfunction

    always_comb begin
        fwdRsD = pickSrc(rsD, 1'b1);
        fwdRtD = pickSrc(rtD, 1'b1);
        fwdRsE = pickSrc(rsE, 1'b0);
        fwdRtE = pickSrc(rtE, 1'b0);
    end

endmodule

`default_nettype wire

// File: instrDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecode (
    input  isaPkg::wordT  instr,
    output pipePkg::ctrlT ctrl
);
    import isaPkg::*;
    import pipePkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regIdxT     rt;
    regIdxT     rd;

    assign opcode = instr[OP_LSB +: 6];
    assign funct  = instr[FN_W-1:0];
    assign rt     = instr[RT_LSB +: $bits(regIdxT)];
    assign rd     = instr[RD_LSB +: $bits(regIdxT)];

    always_comb begin
        ctrl = '0;
        unique case (opcode)
            OP_SPECIAL: begin
                if (funct == FN_ADDU || funct == FN_SUBU) begin
                    ctrl.aluOp   = (funct == FN_SUBU) ? ALU_SUB : ALU_ADD;
                    ctrl.wReg    = rd;
                    ctrl.readsRs = 1'b1;
                    ctrl.readsRt = 1'b1;
                    ctrl.tuseRs  = TUSE_ALU;
                    ctrl.tuseRt  = TUSE_ALU;
                    ctrl.tnew    = TNEW_ALU;
                end
            end
            OP_ORI: begin
                ctrl.aluOp   = ALU_OR;
                ctrl.immB    = 1'b1;
                ctrl.zeroExt = 1'b1;
                ctrl.wReg    = rt;
                ctrl.readsRs = 1'b1;
                ctrl.tuseRs  = TUSE_ALU;
                ctrl.tnew    = TNEW_ALU;
            end
            OP_LUI: begin
                ctrl.aluOp = ALU_LUI;
                ctrl.immB  = 1'b1;
                ctrl.wReg  = rt;
                ctrl.tnew  = TNEW_ALU;
            end
            OP_LW, OP_LB: begin
                ctrl.immB      = 1'b1;
                ctrl.wReg      = rt;
                ctrl.memRead   = 1'b1;
                ctrl.byteWidth = (opcode == OP_LB);
                ctrl.readsRs   = 1'b1;
                ctrl.tuseRs    = TUSE_ALU;
                ctrl.tnew      = TNEW_LOAD;
            end
            OP_SW, OP_SB: begin
                // Store data is not needed until M
                ctrl.immB      = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.byteWidth = (opcode == OP_SB);
                ctrl.readsRs   = 1'b1;
                ctrl.readsRt   = 1'b1;
                ctrl.tuseRs    = TUSE_ALU;
                ctrl.tuseRt    = TUSE_STORE;
            end
            OP_BEQ: begin
                ctrl.branch  = 1'b1;
                ctrl.readsRs = 1'b1;
                ctrl.readsRt = 1'b1;
                ctrl.tuseRs  = TUSE_BRANCH;
                ctrl.tuseRt  = TUSE_BRANCH;
            end
            OP_J: begin
                ctrl.jump = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: isaPkg.sv
`default_nettype none

package isaPkg;

    typedef logic [4:0] regIdxT;
    typedef logic [31:0] wordT;

    // Primary opcodes, bits 31:26
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // Function codes under OP_SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;

    // Field positions
    localparam int OP_LSB  = 26;
    localparam int RS_LSB  = 21;
    localparam int RT_LSB  = 16;
    localparam int RD_LSB  = 11;
    localparam int IMM_W   = 16;
    localparam int INDEX_W = 26;
    localparam int FN_W    = 6;

endpackage

`default_nettype wire

// File: memAccess.sv
`timescale 1ns/10ps
`default_nettype none

module memAccess (
    input  pipePkg::ctrlT ctrl,
    input  isaPkg::wordT  addr,
    input  isaPkg::wordT  storeVal,
    input  isaPkg::wordT  rdata,
    output logic [3:0]    byteen,
    output isaPkg::wordT  wdata,
    output isaPkg::wordT  loadVal
);
    import isaPkg::*;
    import pipePkg::*;

    logic [1:0] lane;
    logic [7:0] loadByte;

    assign lane = addr[1:0];

    // Little-endian lanes; byte stores put the byte on every lane
    always_comb begin
        if (!ctrl.memWrite) begin
            byteen = 4'b0000;
        end else if (ctrl.byteWidth) begin
            byteen = 4'b0001 << lane;
        end else begin
            byteen = 4'b1111;
        end
    end

    assign wdata = ctrl.byteWidth ? {4{storeVal[7:0]}} : storeVal;

    assign loadByte = rdata[8*lane +: 8];
    assign loadVal  = ctrl.byteWidth ? {{24{loadByte[7]}}, loadByte} : rdata;

endmodule

`default_nettype wire

// File: mips.sv
`timescale 1ns/10ps
`default_nettype none

module mips (
    input  logic           clk,
    input  logic           rstN,
    output isaPkg::wordT   instAddr,
    input  isaPkg::wordT   instRdata,
    output isaPkg::wordT   dataAddr,
    output isaPkg::wordT   dataWdata,
    output logic [3:0]     dataByteen,
    output isaPkg::wordT   memInstAddr,
    input  isaPkg::wordT   dataRdata,
    output logic           grfWe,
    output isaPkg::regIdxT grfAddr,
    output isaPkg::wordT   grfWdata,
    output isaPkg::wordT   grfInstAddr
);
    import isaPkg::*;
    import pipePkg::*;

    logic        stall;
    decodeStageT fetched;
    decodeStageT decQ;
    execStageT   execD;
    execStageT   execQ;
    memStageT    memD;
    memStageT    memQ;
    wbStageT     wbD;
    wbStageT     wbQ;
    ctrlT        ctrlD;
    regIdxT      rsD;
    regIdxT      rtD;
    regIdxT      rsE;
    regIdxT      rtE;
    wordT        rfRs;
    wordT        rfRt;
    wordT        rsValD;
    wordT        rtValD;
    wordT        rsValE;
    wordT        rtValE;
    wordT        aluResE;
    wordT        storeValM;
    wordT        wdataM;
    wordT        loadValM;
    logic [3:0]  byteenM;
    fwdSrcT      fwdRsD;
    fwdSrcT      fwdRtD;
    fwdSrcT      fwdRsE;
    fwdSrcT      fwdRtE;
    memWriteT    storeM;
    regWriteT    traceW;

    fetchUnit uFetch (
        .clk(clk), .rstN(rstN), .stall(stall),
        .pcD(decQ.pc), .instrD(decQ.instr), .rsVal(rsValD), .rtVal(rtValD),
        .ctrlD(ctrlD), .instRdata(instRdata), .instAddr(instAddr), .fetched(fetched)
    );

    // D holds on stall while E takes a bubble
    stageReg #(.payloadT(decodeStageT)) uRegD (
        .clk(clk), .rstN(rstN), .en(!stall), .flush(1'b0), .d(fetched), .q(decQ)
    );

    assign rsD = decQ.instr[RS_LSB +: $bits(regIdxT)];
    assign rtD = decQ.instr[RT_LSB +: $bits(regIdxT)];

    instrDecode uDecode (.instr(decQ.instr), .ctrl(ctrlD));

    regFile uRegs (
        .clk(clk), .rstN(rstN), .ra1(rsD), .ra2(rtD),
        .wa(wbQ.wReg), .wd(wbQ.data), .rd1(rfRs), .rd2(rfRt)
    );

    hazardUnit uHazard (
        .ctrlD(ctrlD), .rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
        .ctrlE(execQ.ctrl), .ctrlM(memQ.ctrl), .wbReg(wbQ.wReg), .stall(stall),
        .fwdRsD(fwdRsD), .fwdRtD(fwdRtD), .fwdRsE(fwdRsE), .fwdRtE(fwdRtE)
    );

    // D-stage operands, also used for the branch compare
    assign rsValD = (fwdRsD == FWD_E) ? aluResE :
                    (fwdRsD == FWD_M) ? memQ.aluRes :
                    (fwdRsD == FWD_W) ? wbQ.data : rfRs;
    assign rtValD = (fwdRtD == FWD_E) ? aluResE :
                    (fwdRtD == FWD_M) ? memQ.aluRes :
                    (fwdRtD == FWD_W) ? wbQ.data : rfRt;

    assign execD = '{instr: decQ.instr, pc: decQ.pc, ctrl: ctrlD,
                     rsVal: rsValD, rtVal: rtValD};

    stageReg #(.payloadT(execStageT)) uRegE (
        .clk(clk), .rstN(rstN), .en(1'b1), .flush(stall), .d(execD), .q(execQ)
    );

    assign rsE = execQ.instr[RS_LSB +: $bits(regIdxT)];
    assign rtE = execQ.instr[RT_LSB +: $bits(regIdxT)];

    assign rsValE = (fwdRsE == FWD_M) ? memQ.aluRes :
                    (fwdRsE == FWD_W) ? wbQ.data : execQ.rsVal;
    assign rtValE = (fwdRtE == FWD_M) ? memQ.aluRes :
                    (fwdRtE == FWD_W) ? wbQ.data : execQ.rtVal;

    executeUnit uExec (
        .ctrl(execQ.ctrl), .imm(execQ.instr[IMM_W-1:0]),
        .a(rsValE), .b(rtValE), .result(aluResE)
    );

    assign memD = '{pc: execQ.pc, ctrl: execQ.ctrl, rt: rtE,
                    aluRes: aluResE, rtVal: rtValE};

    stageReg #(.payloadT(memStageT)) uRegM (
        .clk(clk), .rstN(rstN), .en(1'b1), .flush(1'b0), .d(memD), .q(memQ)
    );

    // A load one ahead of a store reaches W just as the store needs its data
    assign storeValM = (memQ.rt != '0 && memQ.rt == wbQ.wReg) ? wbQ.data : memQ.rtVal;

    memAccess uMem (
        .ctrl(memQ.ctrl), .addr(memQ.aluRes), .storeVal(storeValM), .rdata(dataRdata),
        .byteen(byteenM), .wdata(wdataM), .loadVal(loadValM)
    );

    assign storeM      = '{addr: memQ.aluRes, data: wdataM, byteen: byteenM};
    assign dataAddr    = storeM.addr;
    assign dataWdata   = storeM.data;
    assign dataByteen  = storeM.byteen;
    assign memInstAddr = memQ.pc;

    assign wbD = '{pc: memQ.pc, wReg: memQ.ctrl.wReg,
                   data: memQ.ctrl.memRead ? loadValM : memQ.aluRes};

    stageReg #(.payloadT(wbStageT)) uRegW (
        .clk(clk), .rstN(rstN), .en(1'b1), .flush(1'b0), .d(wbD), .q(wbQ)
    );

    assign traceW      = '{pc: wbQ.pc, wReg: wbQ.wReg, data: wbQ.data};
    assign grfWe       = (traceW.wReg != '0);
    assign grfAddr     = traceW.wReg;
    assign grfWdata    = traceW.data;
    assign grfInstAddr = traceW.pc;

endmodule

`default_nettype wire

// File: mips_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module mipsAsserts (
    input logic         clk,
    input logic         rstN,
    input logic         stall,
    input logic         grfWe,
    input isaPkg::wordT grfInstAddr,
    input isaPkg::wordT instAddr,
    input logic [3:0]   dataByteen
);

    // Each instruction leaves W once, so back-to-back retirements differ in PC
    retireOnce: assert property (@(posedge clk) disable iff (!rstN)
        grfWe && $past(grfWe) |-> grfInstAddr != $past(grfInstAddr))
        else $error("same instruction retired twice in a row");

    // A stalled fetch keeps its address
    frozenFetch: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> $stable(instAddr))
        else $error("instAddr moved during a stall");

    quietReset: assert property (@(posedge clk)
        !rstN |-> dataByteen == 4'b0000)
        else $error("store enabled while in reset");

endmodule

bind mips mipsAsserts uAsserts (
    .clk(clk), .rstN(rstN), .stall(stall), .grfWe(grfWe), .grfInstAddr(grfInstAddr),
    .instAddr(instAddr), .dataByteen(dataByteen)
);

`default_nettype wire

// File: pipePkg.sv
`default_nettype none

package pipePkg;

    localparam isaPkg::wordT RESET_PC = 32'h0000_3000;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_OR  = 2'd2,
        ALU_LUI = 2'd3
    } aluOpT;

    // Cycles until a value is needed (use) or produced (new)
    typedef logic [1:0] timeT;

    localparam timeT TUSE_BRANCH = 2'd0;
    localparam timeT TUSE_ALU    = 2'd1;
    localparam timeT TUSE_STORE  = 2'd2;
    localparam timeT TNEW_ALU    = 2'd1;
    localparam timeT TNEW_LOAD   = 2'd2;

    // All-zero value is a bubble
    typedef struct packed {
        aluOpT          aluOp;
        logic           immB;
        logic           zeroExt;
        isaPkg::regIdxT wReg;
        logic           memWrite;
        logic           memRead;
        logic           byteWidth;
        logic           branch;
        logic           jump;
        logic           readsRs;
        logic           readsRt;
        timeT           tuseRs;
        timeT           tuseRt;
        timeT           tnew;
    } ctrlT;

    typedef struct packed {
        isaPkg::wordT instr;
        isaPkg::wordT pc;
    } decodeStageT;

    typedef struct packed {
        isaPkg::wordT instr;
        isaPkg::wordT pc;
        ctrlT         ctrl;
        isaPkg::wordT rsVal;
        isaPkg::wordT rtVal;
    } execStageT;

    // rt kept so store data can still pick up a load result from W
    typedef struct packed {
        isaPkg::wordT   pc;
        ctrlT           ctrl;
        isaPkg::regIdxT rt;
        isaPkg::wordT   aluRes;
        isaPkg::wordT   rtVal;
    } memStageT;

    typedef struct packed {
        isaPkg::wordT   pc;
        isaPkg::regIdxT wReg;
        isaPkg::wordT   data;
    } wbStageT;

    typedef struct packed {
        isaPkg::wordT   pc;
        isaPkg::regIdxT wReg;
        isaPkg::wordT   data;
    } regWriteT;

    typedef struct packed {
        isaPkg::wordT addr;
        isaPkg::wordT data;
        logic [3:0]   byteen;
    } memWriteT;

    typedef enum logic [1:0] {
        FWD_RF = 2'd0,
        FWD_E  = 2'd1,
        FWD_M  = 2'd2,
        FWD_W  = 2'd3
    } fwdSrcT;

endpackage

`default_nettype wire

// File: project.f
isaPkg.sv
pipePkg.sv
stageReg.sv
fetchUnit.sv
instrDecode.sv
regFile.sv
hazardUnit.sv
executeUnit.sv
memAccess.sv
mips.sv
mips_asserts.sv
tbMips.sv

// File: regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  isaPkg::regIdxT ra1,
    input  isaPkg::regIdxT ra2,
    input  isaPkg::regIdxT wa,
    input  isaPkg::wordT   wd,
    output isaPkg::wordT   rd1,
    output isaPkg::wordT   rd2
);
    import isaPkg::*;

    wordT regs [32];

    // Register 0 is never written so it stays zero after reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Write-through bypass for the register retiring this cycle
    assign rd1 = (wa != '0 && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (wa != '0 && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then decide from the simulation log
rm -f sim.log
verilator --binary --timing --assert --top-module tbMips -f project.f -o simMips &&
    ./obj_dir/simMips | tee sim.log ||
    echo "Build or simulation did not complete"
grep -q "ALL CHECKS PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }

// File: stageReg.sv
`timescale 1ns/10ps
`default_nettype none

module stageReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    en,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // Flush wins over enable and inserts a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: tbMips.sv
`timescale 1ns/10ps
`default_nettype none

module tbMips;
    import isaPkg::*;
    import pipePkg::*;

    localparam int   IMEM_WORDS = 256;
    localparam int   DMEM_BYTES = 1024;
    localparam int   WAIT_LIMIT = 4000;
    localparam wordT DATA_BASE  = 32'h0000_0100;

    logic       clk;
    logic       rstN;
    wordT       instAddr;
    wordT       instRdata;
    wordT       dataAddr;
    wordT       dataWdata;
    logic [3:0] dataByteen;
    wordT       memInstAddr;
    wordT       dataRdata;
    logic       grfWe;
    regIdxT     grfAddr;
    wordT       grfWdata;
    wordT       grfInstAddr;

    wordT       imem [IMEM_WORDS];
    logic [7:0] dmem [DMEM_BYTES];
    wordT       imemOff;
    wordT       endAddr;
    int         progLen;
    logic [31:0] lfsr;
    regWriteT   expRegs [$];
    memWriteT   expMems [$];
    wordT       expStorePcs [$];
    int         regChecks;
    int         memChecks;
    int         regErrors;
    int         memErrors;
    int         otherErrors;

    mips dut0 (
        .clk(clk), .rstN(rstN), .instAddr(instAddr), .instRdata(instRdata),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataByteen(dataByteen),
        .memInstAddr(memInstAddr), .dataRdata(dataRdata), .grfWe(grfWe),
        .grfAddr(grfAddr), .grfWdata(grfWdata), .grfInstAddr(grfInstAddr)
    );

    always #20 clk = ~clk;

    // Instruction memory, nops outside the program
    assign imemOff   = instAddr - RESET_PC;
    assign instRdata = (imemOff < wordT'(4 * IMEM_WORDS)) ? imem[imemOff[9:2]] : '0;

    // Little-endian data memory, word read at the aligned address
    assign dataRdata = {dmem[{dataAddr[9:2], 2'd3}], dmem[{dataAddr[9:2], 2'd2}],
                        dmem[{dataAddr[9:2], 2'd1}], dmem[{dataAddr[9:2], 2'd0}]};

    always @(posedge clk) begin
        if (dataByteen[0]) dmem[{dataAddr[9:2], 2'd0}] <= dataWdata[7:0];
        if (dataByteen[1]) dmem[{dataAddr[9:2], 2'd1}] <= dataWdata[15:8];
        if (dataByteen[2]) dmem[{dataAddr[9:2], 2'd2}] <= dataWdata[23:16];
        if (dataByteen[3]) dmem[{dataAddr[9:2], 2'd3}] <= dataWdata[31:24];
    end

    function automatic logic [7:0] memFill(input int unsigned a);
        return 8'(a ^ (a >> 3) ^ (a >> 8) ^ 32'h5a);
    endfunction

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
        return v;
    endfunction

    function automatic wordT encR(input regIdxT rs, input regIdxT rt, input regIdxT rd,
                                  input logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT encI(input logic [5:0] op, input regIdxT rs, input regIdxT rt,
                                  input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT encJ(input wordT target);
        return {OP_J, target[27:2]};
    endfunction

    task automatic emit(input wordT w);
        imem[8'(progLen)] = w;
        progLen++;
    endtask

    task automatic buildProgram();
        regIdxT     rd;
        regIdxT     rs;
        regIdxT     rt;
        logic [1:0] kind;
        logic [7:0] off;
        wordT       here;
        progLen = 0;
        // Seed registers 1..8, each ori right behind its lui
        for (int i = 1; i <= 8; i++) begin
            rd = 5'(i);
            emit(encI(OP_LUI, 5'd0, rd, 16'(randBits(16))));
            emit(encI(OP_ORI, rd, rd, 16'(randBits(16))));
        end
        // Random ALU mix over registers 1..8
        for (int i = 0; i < 16; i++) begin
            kind = 2'(randBits(2));
            rd   = 5'(randBits(3)) + 5'd1;
            rs   = 5'(randBits(3)) + 5'd1;
            rt   = 5'(randBits(3)) + 5'd1;
            case (kind)
                2'd0: emit(encR(rs, rt, rd, FN_ADDU));
                2'd1: emit(encR(rs, rt, rd, FN_SUBU));
                2'd2: emit(encI(OP_ORI, rs, rd, 16'(randBits(16))));
                default: emit(encI(OP_LUI, 5'd0, rd, 16'(randBits(16))));
            endcase
        end
        // Back-to-back dependent chain
        emit(encR(5'd1, 5'd2, 5'd9, FN_ADDU));
        emit(encR(5'd9, 5'd3, 5'd10, FN_SUBU));
        emit(encR(5'd10, 5'd9, 5'd11, FN_ADDU));
        emit(encI(OP_ORI, 5'd11, 5'd12, 16'(randBits(16))));
        // Loads, stores and load-use
        emit(encI(OP_ORI, 5'd0, 5'd20, DATA_BASE[15:0]));
        emit(encI(OP_SW, 5'd20, 5'd1, 16'd0));
        emit(encI(OP_LW, 5'd20, 5'd13, 16'd0));
        emit(encR(5'd13, 5'd1, 5'd14, FN_ADDU));
        emit(encI(OP_LW, 5'd20, 5'd15, 16'd4));
        emit(encI(OP_SW, 5'd20, 5'd15, 16'd8));
        emit(encI(OP_ORI, 5'd0, 5'd16, 16'h0080));
        emit(encI(OP_SB, 5'd20, 5'd16, 16'd6));
        emit(encI(OP_LB, 5'd20, 5'd17, 16'd6));
        emit(encI(OP_LW, 5'd20, 5'd18, 16'd4));
        emit(encI(OP_LB, 5'd20, 5'd18, 16'h0203));
        for (int i = 0; i < 6; i++) begin
            off = 8'(randBits(8));
            rt  = 5'(randBits(3)) + 5'd1;
            emit(encI(OP_SB, 5'd20, rt, {8'h00, off}));
            emit(encI(OP_LB, 5'd20, 5'd19, {8'h00, off}));
            emit(encI(OP_SW, 5'd20, 5'd19, {8'h01, off[7:2], 2'b00}));
        end
        // Taken beq right after its ALU operand, then not taken
        emit(encI(OP_ORI, 5'd0, 5'd21, 16'h0005));
        emit(encI(OP_ORI, 5'd0, 5'd22, 16'h0005));
        emit(encI(OP_BEQ, 5'd21, 5'd22, 16'd2));
        emit(encR(5'd21, 5'd22, 5'd23, FN_ADDU));
        emit(encI(OP_ORI, 5'd0, 5'd24, 16'hdead));
        emit(encI(OP_BEQ, 5'd21, 5'd0, 16'd2));
        emit(encR(5'd22, 5'd21, 5'd24, FN_SUBU));
        emit(encI(OP_ORI, 5'd24, 5'd25, 16'h0011));
        here = RESET_PC + 32'(4 * progLen);
        emit(encJ(here + 32'd12));
        emit(encI(OP_ORI, 5'd0, 5'd26, 16'h0026));
        emit(encI(OP_ORI, 5'd0, 5'd26, 16'hbad0));
        // Branch on a fresh load result
        emit(encI(OP_LW, 5'd20, 5'd27, 16'd0));
        emit(encI(OP_BEQ, 5'd27, 5'd1, 16'd2));
        emit(encR(5'd27, 5'd0, 5'd28, FN_ADDU));
        emit(encI(OP_ORI, 5'd0, 5'd28, 16'hbad1));
        // Register 0 stays zero
        emit(encR(5'd1, 5'd2, 5'd0, FN_ADDU));
        emit(encI(OP_ORI, 5'd0, 5'd0, 16'h1234));
        emit(encI(OP_LW, 5'd20, 5'd0, 16'd0));
        emit(encR(5'd0, 5'd0, 5'd29, FN_ADDU));
        emit(encI(OP_ORI, 5'd29, 5'd30, 16'h0030));
    endtask

    // Instruction-level model with a delay slot after every branch and jump
    function automatic void runReference();
        wordT       r [32];
        logic [7:0] m [DMEM_BYTES];
        wordT       pc;
        wordT       npc;
        wordT       target;
        wordT       ins;
        wordT       addr;
        wordT       v;
        wordT       immS;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     dest;
        int         steps;
        r = '{default: '0};
        for (int a = 0; a < DMEM_BYTES; a++) begin
            m[10'(a)] = memFill(a);
        end
        pc    = RESET_PC;
        npc   = RESET_PC + 32'd4;
        steps = 0;
        while (pc >= RESET_PC && pc < RESET_PC + 32'(4 * progLen) && steps < 1000) begin
            ins    = imem[8'((pc - RESET_PC) >> 2)];
            rs     = ins[25:21];
            rt     = ins[20:16];
            immS   = {{16{ins[15]}}, ins[15:0]};
            addr   = r[rs] + immS;
            dest   = '0;
            v      = '0;
            target = npc + 32'd4;
            case (ins[31:26])
                OP_SPECIAL: begin
                    if (ins[5:0] == FN_ADDU || ins[5:0] == FN_SUBU) begin
                        dest = ins[15:11];
                        v    = (ins[5:0] == FN_ADDU) ? r[rs] + r[rt] : r[rs] - r[rt];
                    end
                end
                OP_ORI: begin
                    dest = rt;
                    v    = r[rs] | {16'h0000, ins[15:0]};
                end
                OP_LUI: begin
                    dest = rt;
                    v    = {ins[15:0], 16'h0000};
                end
                OP_LW: begin
                    dest = rt;
                    v    = {m[{addr[9:2], 2'd3}], m[{addr[9:2], 2'd2}],
                            m[{addr[9:2], 2'd1}], m[{addr[9:2], 2'd0}]};
                end
                OP_LB: begin
                    dest = rt;
                    v    = {{24{m[addr[9:0]][7]}}, m[addr[9:0]]};
                end
                OP_SW: begin
                    m[{addr[9:2], 2'd0}] = r[rt][7:0];
                    m[{addr[9:2], 2'd1}] = r[rt][15:8];
                    m[{addr[9:2], 2'd2}] = r[rt][23:16];
                    m[{addr[9:2], 2'd3}] = r[rt][31:24];
                    expMems.push_back(memWriteT'{addr: addr, data: r[rt], byteen: 4'b1111});
                    expStorePcs.push_back(pc);
                end
                OP_SB: begin
                    m[addr[9:0]] = r[rt][7:0];
                    expMems.push_back(memWriteT'{addr: addr, data: {4{r[rt][7:0]}},
                                                 byteen: 4'b0001 << addr[1:0]});
                    expStorePcs.push_back(pc);
                end
                OP_BEQ: begin
                    if (r[rs] == r[rt]) begin
                        target = npc + {immS[29:0], 2'b00};
                    end
                end
                OP_J: begin
                    target = {npc[31:28], ins[25:0], 2'b00};
                end
                default: begin
                end
            endcase
            if (dest != '0) begin
                r[dest] = v;
                expRegs.push_back(regWriteT'{pc: pc, wReg: dest, data: v});
            end
            pc  = npc;
            npc = target;
            steps++;
        end
    endfunction

    task automatic checkRegWrite(input regWriteT exp, input regWriteT act);
        regChecks++;
        if (act !== exp) begin
            regErrors++;
            if (act.pc !== exp.pc)
                $display("[FAIL] grfInstAddr expected %h actual %h", exp.pc, act.pc);
            if (act.wReg !== exp.wReg)
                $display("[FAIL] grfAddr expected %h actual %h", exp.wReg, act.wReg);
            if (act.data !== exp.data)
                $display("[FAIL] grfWdata expected %h actual %h", exp.data, act.data);
        end
    endtask

    task automatic checkMemWrite(input memWriteT exp, input memWriteT act);
        memChecks++;
        if (act !== exp) begin
            memErrors++;
            if (act.addr !== exp.addr)
                $display("[FAIL] dataAddr expected %h actual %h", exp.addr, act.addr);
            if (act.data !== exp.data)
                $display("[FAIL] dataWdata expected %h actual %h", exp.data, act.data);
            if (act.byteen !== exp.byteen)
                $display("[FAIL] dataByteen expected %h actual %h", exp.byteen, act.byteen);
        end
    endtask

    // PC of the instruction that issues the store
    task automatic checkStorePc(input wordT exp, input wordT act);
        if (act !== exp) begin
            memErrors++;
            $display("[FAIL] memInstAddr expected %h actual %h", exp, act);
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rstN && grfWe) begin
            if (expRegs.size() == 0) begin
                $display("Unexpected register write to r%0d from pc %h", grfAddr, grfInstAddr);
                otherErrors++;
            end else begin
                checkRegWrite(expRegs.pop_front(),
                              regWriteT'{pc: grfInstAddr, wReg: grfAddr, data: grfWdata});
            end
        end
        if (rstN && dataByteen != 4'b0000) begin
            if (expMems.size() == 0) begin
                $display("Unexpected store to address %h", dataAddr);
                otherErrors++;
            end else begin
                checkMemWrite(expMems.pop_front(),
                              memWriteT'{addr: dataAddr, data: dataWdata, byteen: dataByteen});
                checkStorePc(expStorePcs.pop_front(), memInstAddr);
            end
        end
    end

    task automatic waitQueuesEmpty();
        int cycles;
        cycles = 0;
        while ((expRegs.size() != 0 || expMems.size() != 0) && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (expRegs.size() != 0 || expMems.size() != 0) begin
            $display("Timed out with %0d register writes and %0d stores still missing",
                     expRegs.size(), expMems.size());
            otherErrors++;
        end
    endtask

    // Let fetch run well past the end so stray writes would show up
    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (instAddr < endAddr + 32'd32 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (instAddr < endAddr + 32'd32) begin
            $display("Timed out waiting for fetch to run past the end of the program");
            otherErrors++;
        end
    endtask

    task automatic finishRun();
        int total;
        total = regErrors + memErrors + otherErrors;
        $display("Checked %0d register writes and %0d stores, errors: %0d reg %0d mem %0d other",
                 regChecks, memChecks, regErrors, memErrors, otherErrors);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        lfsr        = 32'hca03ecb3;
        regChecks   = 0;
        memChecks   = 0;
        regErrors   = 0;
        memErrors   = 0;
        otherErrors = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[8'(i)] = '0;
        end
        for (int a = 0; a < DMEM_BYTES; a++) begin
            dmem[10'(a)] = memFill(a);
        end
        buildProgram();
        endAddr = RESET_PC + 32'(4 * progLen);
        runReference();
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        waitQueuesEmpty();
        waitDrain();
        finishRun();
    end

endmodule

`default_nettype wire
